/* include/iagc_macros.svh */
`ifndef IAGC_MACROS_SVH
`define IAGC_MACROS_SVH

// accepted samples per measurement window
`define IAGC_WINDOW 256

// signed adc sample width
`define IAGC_SAMPLE_W 14

// peak-to-peak result width
`define IAGC_AMP_W 16

// sync byte that opens every frame
`define IAGC_FRAME_HDR 8'hA5

// 100 MHz / 921600 baud, rounded
`define IAGC_CLKS_PER_BIT_DEF 109

`endif

/* verilog/iagc_pkg.sv */
package iagc_pkg;

  // global measurement status
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_MEASURE = 2'd1,
    ST_LOG     = 2'd2
  } iagc_status_e;

  // one-hot rgb patterns, bit order {r, g, b}
  typedef enum logic [2:0] {
    LED_OFF   = 3'b000,
    LED_RED   = 3'b100,
    LED_GREEN = 3'b010,
    LED_BLUE  = 3'b001
  } led_colour_e;

endpackage

/* verilog/iagc_meas_if.sv */
`timescale 1ns/10ps
`include "iagc_macros.svh"

interface iagc_meas_if;

  // peak-to-peak per channel, held until next clear
  logic [`IAGC_AMP_W-1:0] ref_amp;
  logic [`IAGC_AMP_W-1:0] err_amp;
  // sign vote verdict
  logic                   in_phase;
  // end of window, one cycle
  logic                   valid;
  // window start, one cycle
  logic                   clear;

  modport src_amp (output ref_amp, output err_amp, output valid, input clear);
  modport src_phase (output in_phase, input clear);
  modport sink (input ref_amp, input err_amp, input in_phase, input valid, output clear);

endinterface

/* verilog/iagc_fsm.sv */
`timescale 1ns/10ps

module iagc_fsm (
  input  logic                   i_clock,
  input  logic                   i_rst_n,
  input  logic                   i_sample,
  input  logic                   i_gate,
  input  logic                   i_adc_valid,
  iagc_meas_if.sink              meas,
  input  logic                   i_frame_done,
  output logic                   o_strobe,
  output iagc_pkg::iagc_status_e o_status
);

  iagc_pkg::iagc_status_e status_q;

  // idle -> measure on request, measure -> log at end of window,
  // log -> idle once the frame is out
  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      status_q <= iagc_pkg::ST_IDLE;
    end else begin
      case (status_q)
        iagc_pkg::ST_IDLE: begin
          if (i_sample) begin
            status_q <= iagc_pkg::ST_MEASURE;
          end
        end
        iagc_pkg::ST_MEASURE: begin
          if (meas.valid) begin
            status_q <= iagc_pkg::ST_LOG;
          end
        end
        iagc_pkg::ST_LOG: begin
          if (i_frame_done) begin
            status_q <= iagc_pkg::ST_IDLE;
          end
        end
        default: status_q <= iagc_pkg::ST_IDLE;
      endcase
    end
  end

  // window start pulse, same cycle as the idle->measure decision
  assign meas.clear = (status_q == iagc_pkg::ST_IDLE) && i_sample;

  // qualified sample, only while measuring
  assign o_strobe = i_adc_valid && i_gate && (status_q == iagc_pkg::ST_MEASURE);
  assign o_status = status_q;

endmodule

/* verilog/amplitude_detector.sv */
`timescale 1ns/10ps
`include "iagc_macros.svh"

module amplitude_detector (
  input  logic                             i_clock,
  input  logic                             i_rst_n,
  input  logic                             i_strobe,
  input  logic signed [`IAGC_SAMPLE_W-1:0] i_adc_ref,
  input  logic signed [`IAGC_SAMPLE_W-1:0] i_adc_err,
  iagc_meas_if.src_amp                     meas
);

  localparam int W     = `IAGC_SAMPLE_W;
  localparam int AMP_W = `IAGC_AMP_W;
  localparam int CNT_W = $clog2(`IAGC_WINDOW + 1);
  // start values so the first sample always wins
  localparam logic signed [W-1:0] S_MIN = {1'b1, {(W-1){1'b0}}};
  localparam logic signed [W-1:0] S_MAX = {1'b0, {(W-1){1'b1}}};

  // index 0 is the reference channel, 1 the error channel
  logic signed [W-1:0] smp   [2];
  logic signed [W-1:0] max_q [2];
  logic signed [W-1:0] min_q [2];
  logic signed [W-1:0] max_d [2];
  logic signed [W-1:0] min_d [2];
  logic        [W:0]   p2p   [2];
  logic [CNT_W-1:0]    cnt;
  logic                take;
  logic                last;

  assign smp[0] = i_adc_ref;
  assign smp[1] = i_adc_err;

  // counter saturates at the window length until the next clear
  assign take = i_strobe && (cnt != CNT_W'(`IAGC_WINDOW));
  assign last = (cnt == CNT_W'(`IAGC_WINDOW - 1));

  // extremes including the current sample
  always_comb begin
    for (int ch = 0; ch < 2; ch++) begin
      max_d[ch] = (smp[ch] > max_q[ch]) ? smp[ch] : max_q[ch];
      min_d[ch] = (smp[ch] < min_q[ch]) ? smp[ch] : min_q[ch];
      // never negative, fits one extra bit
      p2p[ch] = {max_d[ch][W-1], max_d[ch]} - {min_d[ch][W-1], min_d[ch]};
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      cnt        <= '0;
      meas.valid <= 1'b0;
    end else begin
      meas.valid <= 1'b0;
      if (meas.clear) begin
        cnt <= '0;
      end else if (take) begin
        cnt <= cnt + 1'b1;
        meas.valid <= last;
      end
    end
  end

  // tracking and results
  always_ff @(posedge i_clock) begin
    for (int ch = 0; ch < 2; ch++) begin
      if (meas.clear) begin
        max_q[ch] <= S_MIN;
        min_q[ch] <= S_MAX;
      end else if (take) begin
        max_q[ch] <= max_d[ch];
        min_q[ch] <= min_d[ch];
      end
    end
    if (take && last) begin
      meas.ref_amp <= AMP_W'(p2p[0]);
      meas.err_amp <= AMP_W'(p2p[1]);
    end
  end

endmodule

/* verilog/phase_detector.sv */
`timescale 1ns/10ps
`include "iagc_macros.svh"

module phase_detector (
  input  logic                             i_clock,
  input  logic                             i_rst_n,
  input  logic                             i_strobe,
  input  logic signed [`IAGC_SAMPLE_W-1:0] i_adc_ref,
  input  logic signed [`IAGC_SAMPLE_W-1:0] i_adc_err,
  iagc_meas_if.src_phase                   meas
);

  localparam int W     = `IAGC_SAMPLE_W;
  localparam int CNT_W = $clog2(`IAGC_WINDOW + 1);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] agree;
  logic [CNT_W-1:0] agree_nxt;
  logic             same_sign;
  logic             take;
  logic             last;

  // one vote per sample, sign bits equal means in phase
  assign same_sign = (i_adc_ref[W-1] == i_adc_err[W-1]);
  assign take      = i_strobe && (cnt != CNT_W'(`IAGC_WINDOW));
  assign last      = (cnt == CNT_W'(`IAGC_WINDOW - 1));
  assign agree_nxt = agree + CNT_W'(same_sign);

  always_ff @(posedge i_clock) begin
    if (!i_rst_n || meas.clear) begin
      cnt   <= '0;
      agree <= '0;
    end else if (take) begin
      cnt   <= cnt + 1'b1;
      agree <= agree_nxt;
    end
  end

  // strict majority, a tie counts as out of phase
  always_ff @(posedge i_clock) begin
    if (take && last) begin
      meas.in_phase <= (agree_nxt > CNT_W'(`IAGC_WINDOW / 2));
    end
  end

endmodule

/* verilog/logger.sv */
`timescale 1ns/10ps
`include "iagc_macros.svh"

module logger (
  input  logic       i_clock,
  input  logic       i_rst_n,
  iagc_meas_if.sink  meas,
  input  logic       i_tx_ready,
  output logic       o_tx_valid,
  output logic [7:0] o_tx_data,
  output logic       o_frame_done
);

  localparam int AMP_W = `IAGC_AMP_W;

  typedef enum logic [1:0] {
    LG_IDLE,
    LG_SEND,
    LG_DRAIN
  } lg_state_e;

  // frame byte order
  typedef enum logic [2:0] {
    B_HDR,
    B_REF_HI,
    B_REF_LO,
    B_ERR_HI,
    B_ERR_LO,
    B_PHASE
  } frame_byte_e;

  lg_state_e   state;
  frame_byte_e byte_sel;

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      state        <= LG_IDLE;
      byte_sel     <= B_HDR;
      o_frame_done <= 1'b0;
    end else begin
      o_frame_done <= 1'b0;
      case (state)
        LG_IDLE: begin
          if (meas.valid) begin
            state    <= LG_SEND;
            byte_sel <= B_HDR;
          end
        end
        LG_SEND: begin
          if (i_tx_ready) begin
            if (byte_sel == B_PHASE) begin
              state <= LG_DRAIN;
            end else begin
              byte_sel <= frame_byte_e'(byte_sel + 3'd1);
            end
          end
        end
        // wait for the last stop bit before reporting done
        LG_DRAIN: begin
          if (i_tx_ready) begin
            state        <= LG_IDLE;
            o_frame_done <= 1'b1;
          end
        end
        default: state <= LG_IDLE;
      endcase
    end
  end

  assign o_tx_valid = (state == LG_SEND);

  // fields hold until next clear, so the byte stays put under back-pressure
  always_comb begin
    case (byte_sel)
      B_HDR:    o_tx_data = `IAGC_FRAME_HDR;
      B_REF_HI: o_tx_data = meas.ref_amp[AMP_W-1 -: 8];
      B_REF_LO: o_tx_data = meas.ref_amp[7:0];
      B_ERR_HI: o_tx_data = meas.err_amp[AMP_W-1 -: 8];
      B_ERR_LO: o_tx_data = meas.err_amp[7:0];
      B_PHASE:  o_tx_data = {7'd0, meas.in_phase};
      default:  o_tx_data = `IAGC_FRAME_HDR;
    endcase
  end

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/10ps
`include "iagc_macros.svh"

module uart_tx #(
  parameter int CLKS_PER_BIT = `IAGC_CLKS_PER_BIT_DEF
) (
  input  logic       i_clock,
  input  logic       i_rst_n,
  input  logic       i_tx_valid,
  input  logic [7:0] i_tx_data,
  output logic       o_tx_ready,
  output logic       o_tx
);

  localparam int TMR_W = $clog2(CLKS_PER_BIT + 1);

  // stop, data lsb first, start; idle shifts in ones
  logic [9:0]       shreg;
  logic [TMR_W-1:0] timer;
  logic [3:0]       bit_cnt;
  logic             busy;

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      busy    <= 1'b0;
      shreg   <= '1;
      timer   <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      // load on the transfer edge, start bit goes out next cycle
      if (i_tx_valid) begin
        busy    <= 1'b1;
        shreg   <= {1'b1, i_tx_data, 1'b0};
        timer   <= '0;
        bit_cnt <= '0;
      end
    end else if (timer == TMR_W'(CLKS_PER_BIT - 1)) begin
      // end of bit period
      timer   <= '0;
      shreg   <= {1'b1, shreg[9:1]};
      bit_cnt <= bit_cnt + 4'd1;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;
      end
    end else begin
      timer <= timer + 1'b1;
    end
  end

  assign o_tx_ready = !busy;
  assign o_tx       = shreg[0];

endmodule

/* verilog/led_unit.sv */
`timescale 1ns/10ps

module led_unit (
  input  logic                   i_clock,
  input  logic                   i_rst_n,
  input  iagc_pkg::iagc_status_e i_status,
  input  logic                   i_in_phase,
  input  logic                   i_meas_valid,
  output logic                   o_led0_r,
  output logic                   o_led0_g,
  output logic                   o_led0_b,
  output logic                   o_led1_r,
  output logic                   o_led1_g,
  output logic                   o_led1_b
);

  iagc_pkg::led_colour_e led0_q;
  iagc_pkg::led_colour_e led1_q;

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      led0_q <= iagc_pkg::LED_BLUE;
      led1_q <= iagc_pkg::LED_RED;
    end else begin
      // led0 follows status
      case (i_status)
        iagc_pkg::ST_IDLE:    led0_q <= iagc_pkg::LED_BLUE;
        iagc_pkg::ST_MEASURE: led0_q <= iagc_pkg::LED_GREEN;
        iagc_pkg::ST_LOG:     led0_q <= iagc_pkg::LED_RED;
        default:              led0_q <= iagc_pkg::LED_OFF;
      endcase
      // led1 keeps last verdict
      if (i_meas_valid) begin
        led1_q <= i_in_phase ? iagc_pkg::LED_GREEN : iagc_pkg::LED_RED;
      end
    end
  end

  assign {o_led0_r, o_led0_g, o_led0_b} = led0_q;
  assign {o_led1_r, o_led1_g, o_led1_b} = led1_q;

endmodule

/* verilog/iagc_top.sv */
`timescale 1ns/10ps
`include "iagc_macros.svh"

module iagc_top #(
  parameter int CLKS_PER_BIT = `IAGC_CLKS_PER_BIT_DEF
) (
  input  logic                             i_clock,
  input  logic                             i_rst_n,
  input  logic                             i_sample,
  input  logic                             i_gate,
  input  logic                             i_adc_valid,
  input  logic signed [`IAGC_SAMPLE_W-1:0] i_adc_ref,
  input  logic signed [`IAGC_SAMPLE_W-1:0] i_adc_err,
  output logic                             o_tx,
  output logic                             o_led0_r,
  output logic                             o_led0_g,
  output logic                             o_led0_b,
  output logic                             o_led1_r,
  output logic                             o_led1_g,
  output logic                             o_led1_b
);

  iagc_pkg::iagc_status_e status;
  // qualified sample for both detectors
  logic                   strobe;
  logic                   frame_done;
  // logger to uart byte handshake
  logic                   tx_valid;
  logic [7:0]             tx_data;
  logic                   tx_ready;

  iagc_meas_if meas_if ();

  iagc_fsm u_iagc_fsm (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .i_sample     (i_sample),
    .i_gate       (i_gate),
    .i_adc_valid  (i_adc_valid),
    .meas         (meas_if.sink),
    .i_frame_done (frame_done),
    .o_strobe     (strobe),
    .o_status     (status)
  );

  amplitude_detector u_amplitude_detector (
    .i_clock   (i_clock),
    .i_rst_n   (i_rst_n),
    .i_strobe  (strobe),
    .i_adc_ref (i_adc_ref),
    .i_adc_err (i_adc_err),
    .meas      (meas_if.src_amp)
  );

  phase_detector u_phase_detector (
    .i_clock   (i_clock),
    .i_rst_n   (i_rst_n),
    .i_strobe  (strobe),
    .i_adc_ref (i_adc_ref),
    .i_adc_err (i_adc_err),
    .meas      (meas_if.src_phase)
  );

  logger u_logger (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .meas         (meas_if.sink),
    .i_tx_ready   (tx_ready),
    .o_tx_valid   (tx_valid),
    .o_tx_data    (tx_data),
    .o_frame_done (frame_done)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx (
    .i_clock    (i_clock),
    .i_rst_n    (i_rst_n),
    .i_tx_valid (tx_valid),
    .i_tx_data  (tx_data),
    .o_tx_ready (tx_ready),
    .o_tx       (o_tx)
  );

  led_unit u_led_unit (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .i_status     (status),
    .i_in_phase   (meas_if.in_phase),
    .i_meas_valid (meas_if.valid),
    .o_led0_r     (o_led0_r),
    .o_led0_g     (o_led0_g),
    .o_led0_b     (o_led0_b),
    .o_led1_r     (o_led1_r),
    .o_led1_g     (o_led1_g),
    .o_led1_b     (o_led1_b)
  );

endmodule

/* verification/iagc_top_assert.sv */
`timescale 1ns/10ps

module iagc_top_assert (
  input logic       i_clock,
  input logic       i_rst_n,
  input logic       i_tx,
  input logic [2:0] i_led0,
  input logic [2:0] i_led1,
  input logic       i_tx_valid,
  input logic [7:0] i_tx_data,
  input logic       i_tx_ready
);

  // failures seen so far, read by the testbench summary
  int fail_cnt = 0;

  // serial line idles high whenever led0 shows idle
  tx_idle_high: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    (i_led0 == iagc_pkg::LED_BLUE) |-> i_tx)
    else begin
      $error("o_tx is low while led0 shows idle");
      fail_cnt++;
    end

  // one colour per led at most
  led_one_colour: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    $onehot0(i_led0) && $onehot0(i_led1))
    else begin
      $error("an rgb led drives more than one colour");
      fail_cnt++;
    end

  // byte offered but not taken, must stay put
  tx_hold: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data)))
    else begin
      $error("tx byte changed or was withdrawn while waiting for ready");
      fail_cnt++;
    end

endmodule

// internal byte handshake reached through the top level scope
bind iagc_top iagc_top_assert u_iagc_top_assert (
  .i_clock    (i_clock),
  .i_rst_n    (i_rst_n),
  .i_tx       (o_tx),
  .i_led0     ({o_led0_r, o_led0_g, o_led0_b}),
  .i_led1     ({o_led1_r, o_led1_g, o_led1_b}),
  .i_tx_valid (tx_valid),
  .i_tx_data  (tx_data),
  .i_tx_ready (tx_ready)
);

/* verification/iagc_top_tb.sv */
`timescale 1ns/10ps
`include "iagc_macros.svh"

module iagc_top_tb;

  localparam int W = `IAGC_SAMPLE_W;
  // five windows at three clocks per gated sample plus five frames of 60 bits, doubled
  localparam int TIMEOUT = 2 * (5 * 3 * `IAGC_WINDOW + 5 * 60 * 8);

  logic                i_clock;
  logic                i_rst_n;
  logic                i_sample;
  logic                i_gate;
  logic                i_adc_valid;
  logic signed [W-1:0] i_adc_ref;
  logic signed [W-1:0] i_adc_err;
  logic                o_tx;
  logic                o_led0_r;
  logic                o_led0_g;
  logic                o_led0_b;
  logic                o_led1_r;
  logic                o_led1_g;
  logic                o_led1_b;
  logic [2:0]          led0;
  logic [2:0]          led1;

  // decoded uart bytes of the current test
  logic [7:0]  rx_q [$];
  string       test_name;
  int          err_cnt;
  int          errs_at_start;
  int          tests_run;
  int          tests_failed;
  int          cycles;

  assign led0 = {o_led0_r, o_led0_g, o_led0_b};
  assign led1 = {o_led1_r, o_led1_g, o_led1_b};

  iagc_top #(
    .CLKS_PER_BIT (8)
  ) dut_i (
    .i_clock     (i_clock),
    .i_rst_n     (i_rst_n),
    .i_sample    (i_sample),
    .i_gate      (i_gate),
    .i_adc_valid (i_adc_valid),
    .i_adc_ref   (i_adc_ref),
    .i_adc_err   (i_adc_err),
    .o_tx        (o_tx),
    .o_led0_r    (o_led0_r),
    .o_led0_g    (o_led0_g),
    .o_led0_b    (o_led0_b),
    .o_led1_r    (o_led1_r),
    .o_led1_g    (o_led1_g),
    .o_led1_b    (o_led1_b)
  );

  // 50 MHz
  initial begin
    i_clock = 1'b0;
    forever #10 i_clock = ~i_clock;
  end

  // cycle budget for the whole run
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge i_clock);
      cycles++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // errors from checks here plus the bound assertions
  function automatic int total_errors();
    return err_cnt + dut_i.u_iagc_top_assert.fail_cnt;
  endfunction

  task automatic compare_value(input string what, input int exp, input int act);
    assert (act == exp) else begin
      $display("ERR %s %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errs_at_start = total_errors();
  endtask

  task automatic end_test();
    tests_run++;
    if (total_errors() == errs_at_start) begin
      $display("test %s ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed, %0d errors", test_name, total_errors() - errs_at_start);
    end
  endtask

  // 8n1 receiver, each bit watched over 8 clocks, value taken mid-bit
  initial begin : uart_rx
    logic [9:0] bits;
    logic       first;
    logic       steady;
    forever begin
      @(negedge i_clock);
      if (i_rst_n === 1'b1 && o_tx === 1'b0) begin
        steady = 1'b1;
        for (int b = 0; b < 10; b++) begin
          for (int s = 0; s < 8; s++) begin
            if (b != 0 || s != 0) begin
              @(negedge i_clock);
            end
            if (s == 0) begin
              first = o_tx;
            end else if (o_tx !== first) begin
              steady = 1'b0;
            end
            if (s == 4) begin
              bits[b] = o_tx;
            end
          end
        end
        assert (steady) else begin
          $display("%s: a uart bit did not last 8 clocks", test_name);
          err_cnt++;
        end
        compare_value("start bit", 0, bits[0]);
        compare_value("stop bit", 1, bits[9]);
        rx_q.push_back(bits[8:1]);
      end
    end
  end

  // one measurement window and its frame; poke raises i_sample mid-run
  task automatic run_window(input string name, input bit in_phase, input int mag,
                            input bit poke);
    int          acc = 0;
    int          n = 0;
    int          r;
    int          e;
    int          max_r = -100000;
    int          min_r = 100000;
    int          max_e = -100000;
    int          min_e = 100000;
    int          agree = 0;
    bit          gate;
    bit          seen_green = 1'b0;
    bit          seen_red = 1'b0;
    bit          poked = 1'b0;
    logic [15:0] amp_r;
    logic [15:0] amp_e;
    logic [7:0]  exp_frame [6];
    begin_test(name);
    rx_q.delete();
    // start request, samples follow once measuring
    i_sample = 1'b1;
    @(negedge i_clock);
    i_sample = 1'b0;
    while (acc < `IAGC_WINDOW) begin
      gate = (n % 3) != 2;
      r = 1 + ($urandom % mag);
      e = 1 + ($urandom % mag);
      if ($urandom % 2) begin
        r = -r;
      end
      // in phase shares the sign, anti phase flips it
      e = ((r < 0) == in_phase) ? -e : e;
      if (!gate) begin
        // full-scale pair, would dominate the amplitudes if accepted
        r = (n % 2) ? 8191 : -8192;
        e = (n % 2) ? -8192 : 8191;
      end
      i_adc_valid = 1'b1;
      i_gate = gate;
      i_adc_ref = W'(r);
      i_adc_err = W'(e);
      // request while measuring
      i_sample = poke && (acc == `IAGC_WINDOW / 2);
      if (gate) begin
        max_r = (r > max_r) ? r : max_r;
        min_r = (r < min_r) ? r : min_r;
        max_e = (e > max_e) ? e : max_e;
        min_e = (e < min_e) ? e : min_e;
        agree += ((r < 0) == (e < 0));
        acc++;
      end
      n++;
      @(negedge i_clock);
      if (led0 == iagc_pkg::LED_GREEN) begin
        seen_green = 1'b1;
      end
    end
    i_adc_valid = 1'b0;
    i_gate = 1'b0;
    i_sample = 1'b0;
    // frame goes out under red, one more request here
    while (led0 != iagc_pkg::LED_BLUE) begin
      if (led0 == iagc_pkg::LED_RED && seen_green) begin
        seen_red = 1'b1;
      end
      i_sample = poke && seen_red && !poked;
      poked = poked || i_sample;
      @(negedge i_clock);
    end
    i_sample = 1'b0;
    // a stray run or frame would show up in here
    repeat (40) @(negedge i_clock);
    amp_r = 16'(max_r - min_r);
    amp_e = 16'(max_e - min_e);
    exp_frame = '{`IAGC_FRAME_HDR, amp_r[15:8], amp_r[7:0], amp_e[15:8], amp_e[7:0],
                  8'(agree > `IAGC_WINDOW / 2)};
    assert (seen_green && seen_red) else begin
      $display("%s: led0 did not go green and then red during the run", test_name);
      err_cnt++;
    end
    compare_value("frame length", 6, rx_q.size());
    for (int i = 0; i < 6; i++) begin
      if (i < rx_q.size()) begin
        compare_value($sformatf("frame byte %0d", i), exp_frame[i], rx_q[i]);
      end
    end
    compare_value("led0 after frame", iagc_pkg::LED_BLUE, led0);
    compare_value("led1", (agree > `IAGC_WINDOW / 2) ? iagc_pkg::LED_GREEN : iagc_pkg::LED_RED,
                  led1);
    end_test();
  endtask

  initial begin
    i_rst_n = 1'b0;
    i_sample = 1'b0;
    i_gate = 1'b0;
    i_adc_valid = 1'b0;
    i_adc_ref = '0;
    i_adc_err = '0;
    err_cnt = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(85));
    repeat (16) @(negedge i_clock);
    i_rst_n = 1'b1;
    @(negedge i_clock);
    begin_test("reset");
    compare_value("o_tx", 1, o_tx);
    compare_value("led0", iagc_pkg::LED_BLUE, led0);
    compare_value("led1", iagc_pkg::LED_RED, led1);
    end_test();
    run_window("in_phase", 1'b1, 4000, 1'b0);
    run_window("anti_phase", 1'b0, 4000, 1'b0);
    // small signal, full-scale gated samples would stand out
    run_window("gate_excluded", 1'b1, 40, 1'b0);
    run_window("back_to_back_a", 1'b0, 2000, 1'b1);
    run_window("back_to_back_b", 1'b1, 2000, 1'b1);
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* iagc_top.f */
+incdir+include
verilog/iagc_pkg.sv
verilog/iagc_meas_if.sv
verilog/iagc_fsm.sv
verilog/amplitude_detector.sv
verilog/phase_detector.sv
verilog/logger.sv
verilog/uart_tx.sv
verilog/led_unit.sv
verilog/iagc_top.sv
verification/iagc_top_assert.sv
verification/iagc_top_tb.sv

/* Bender.yml */
package:
  name: iagc_top

sources:
  - include_dirs:
      - include
    files:
      - verilog/iagc_pkg.sv
      - verilog/iagc_meas_if.sv
      - verilog/iagc_fsm.sv
      - verilog/amplitude_detector.sv
      - verilog/phase_detector.sv
      - verilog/logger.sv
      - verilog/uart_tx.sv
      - verilog/led_unit.sv
      - verilog/iagc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/iagc_top_assert.sv
      - verification/iagc_top_tb.sv
